//--- project.f
logic/rot_cfg_pkg.sv
logic/rot_beat_pkg.sv
logic/weight_bank.sv
logic/weight_loader.sv
logic/rotation_sequencer.sv
logic/out_skid.sv
logic/axis_weight_rotator.sv
tb/weight_rotator_chk.sv
tb/tb_weight_rotator.sv

//--- Makefile
TOP := tb_weight_rotator

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f project.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f project.f \
		--Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "^Test completed successfully$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb/tb_weight_rotator.sv
// kernels come from a fixed table; input gaps and output stalls use one fixed xorshift seed
module tb_weight_rotator;
  import rot_cfg_pkg::*;
  import rot_beat_pkg::*;

  localparam int          WORD_WIDTH = 8;
  localparam int          MEMBERS    = 4;
  localparam int          BEAT_W     = WORD_WIDTH * MEMBERS;
  localparam int          NUM_K      = 5;
  localparam int          WMAX       = 16;
  localparam logic [31:0] SEED       = 32'h171356ed;

  typedef struct packed {
    logic [BEAT_W-1:0] data;
    rot_flags_t        user;
    logic              last;
  } beat_t;

  logic              i_clk = 1'b0;
  logic              i_arst_n;
  logic              i_s_valid, i_s_last, i_m_ready;
  logic [BEAT_W-1:0] i_s_data;
  logic              o_s_ready, o_m_valid, o_m_last;
  logic [BEAT_W-1:0] o_m_data;
  rot_flags_t        o_m_user;

  // kernel table, the fourth entry is the minimum size kernel
  int k_kh2      [NUM_K] = '{1, 2, 0, 0, 3};
  int k_kw2      [NUM_K] = '{1, 2, 0, 0, 3};
  int k_cin_1    [NUM_K] = '{2, 1, 4, 0, 0};
  int k_cols_1   [NUM_K] = '{3, 4, 2, 0, 1};
  int k_blocks_1 [NUM_K] = '{2, 1, 0, 0, 1};

  logic [BEAT_W-1:0] wts [NUM_K][WMAX];
  logic [31:0]       rng_main, rng_rdy;
  int                total_out, in_beats, limit_cycles;
  int                n_out, mk, mb, mc, mj;

  axis_weight_rotator #(
    .WORD_WIDTH (WORD_WIDTH),
    .MEMBERS    (MEMBERS)
  ) DUT (
    .i_clk     (i_clk),
    .i_arst_n  (i_arst_n),
    .i_s_valid (i_s_valid),
    .o_s_ready (o_s_ready),
    .i_s_data  (i_s_data),
    .i_s_last  (i_s_last),
    .o_m_valid (o_m_valid),
    .i_m_ready (i_m_ready),
    .o_m_data  (o_m_data),
    .o_m_last  (o_m_last),
    .o_m_user  (o_m_user)
  );

  bind axis_weight_rotator weight_rotator_chk #(
    .WORD_WIDTH (WORD_WIDTH),
    .MEMBERS    (MEMBERS)
  ) CHK (
    .i_clk     (i_clk),
    .i_arst_n  (i_arst_n),
    .i_m_valid (o_m_valid),
    .i_m_ready (i_m_ready),
    .i_m_data  (o_m_data),
    .i_m_user  (o_m_user),
    .i_m_last  (o_m_last)
  );

  always #20 i_clk = ~i_clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // beats in one column pass, kh*cin
  function automatic int pass_len(input int k);
    return (2 * k_kh2[k] + 1) * (k_cin_1[k] + 1);
  endfunction

  function automatic logic [BEAT_W-1:0] header_beat(input int k, input logic [31:0] noise);
    rot_hdr_t          h;
    logic [BEAT_W-1:0] beat;
    h.kh2      = BITS_KH2'(k_kh2[k]);
    h.kw2      = BITS_KW2'(k_kw2[k]);
    h.cin_1    = BITS_CIN'(k_cin_1[k]);
    h.cols_1   = BITS_COLS'(k_cols_1[k]);
    h.blocks_1 = BITS_BLOCKS'(k_blocks_1[k]);
    beat = BEAT_W'(noise);                    // upper bits are don't care
    beat[HDR_BITS-1:0] = h;
    return beat;
  endfunction

  // expected beat j of column c in block b of kernel k
  function automatic beat_t expected_beat(input int k, input int b, input int c, input int j);
    beat_t e;
    int    cols;
    int    blocks;
    cols   = k_cols_1[k] + 1;
    blocks = k_blocks_1[k] + 1;
    e.data                 = wts[k][j];
    e.user.kw2             = BITS_KW2'(k_kw2[k]);
    e.user.is_w_first      = (c == 0) && (j == 0);
    e.user.is_cin_last     = j == pass_len(k) - 1;
    e.user.is_cols_1_k2    = c == cols - 1 - k_kw2[k];
    e.user.is_top_block    = b == 0;
    e.user.is_bottom_block = b == blocks - 1;
    e.last = (b == blocks - 1) && (c == cols - 1) && (j == pass_len(k) - 1);
    return e;
  endfunction

  task automatic check_equal(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %0h expected %0h", $time, name, got, exp);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  // called on a rising edge, returns on the edge that takes the beat
  task automatic send_beat(input logic [BEAT_W-1:0] data, input logic last);
    rng_main = xorshift32(rng_main);
    while (rng_main[1:0] == 2'b00) begin
      i_s_valid <= 1'b0;
      @(posedge i_clk);
      rng_main = xorshift32(rng_main);
    end
    i_s_valid <= 1'b1;
    i_s_data  <= data;
    i_s_last  <= last;
    @(negedge i_clk);
    while (!o_s_ready) @(negedge i_clk);
    @(posedge i_clk);
  endtask

  initial begin
    i_arst_n  = 1'b0;
    i_s_valid = 1'b0;
    i_s_data  = '0;
    i_s_last  = 1'b0;
    i_m_ready = 1'b0;
    rng_main  = SEED;
    rng_rdy   = ~SEED;
    total_out = 0;
    in_beats  = 0;
    for (int k = 0; k < NUM_K; k++) begin
      for (int j = 0; j < WMAX; j++) begin
        rng_main = xorshift32(rng_main);
        wts[k][j] = BEAT_W'(rng_main);
      end
      total_out += pass_len(k) * (k_cols_1[k] + 1) * (k_blocks_1[k] + 1);
      in_beats  += pass_len(k) + 1;
    end
    limit_cycles = (total_out + in_beats) * 8 + 100;

    repeat (2) @(posedge i_clk);
    i_arst_n <= 1'b1;

    // all kernels back to back, the banks take turns
    for (int k = 0; k < NUM_K; k++) begin
      rng_main = xorshift32(rng_main);
      send_beat(header_beat(k, rng_main), 1'b0);
      for (int j = 0; j < pass_len(k); j++) begin
        send_beat(wts[k][j], j == pass_len(k) - 1);
      end
    end
    i_s_valid <= 1'b0;
    i_s_last  <= 1'b0;

    wait (n_out == total_out);
    repeat (20) @(posedge i_clk);      // room for any extra beat to show up
    if (DUT.CHK.n_fail != 0) begin
      $display("a bound assertion on the output stream failed");
      $display("Test failed");
      $fatal(1);
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

  // outputs inactive while in reset
  initial begin
    @(negedge i_clk);
    check_equal("o_s_ready", 64'(o_s_ready), 64'(0));
    check_equal("o_m_valid", 64'(o_m_valid), 64'(0));
  end

  always @(posedge i_clk) begin
    rng_rdy = xorshift32(rng_rdy);
    i_m_ready <= rng_rdy[1:0] != 2'b00;   // stall about one cycle in four
  end

  initial begin
    n_out = 0;
    mk = 0;
    mb = 0;
    mc = 0;
    mj = 0;
  end

  // compare every output transfer with the reference
  always @(negedge i_clk) begin
    beat_t e;
    if (i_arst_n && o_m_valid && i_m_ready) begin
      if (n_out >= total_out) begin
        $display("an output beat arrived after all %0d expected beats", total_out);
        $display("Test failed");
        $fatal(1);
      end else begin
        e = expected_beat(mk, mb, mc, mj);
        check_equal("o_m_data", 64'(o_m_data), 64'(e.data));
        check_equal("o_m_user.kw2", 64'(o_m_user.kw2), 64'(e.user.kw2));
        check_equal("o_m_user.is_w_first", 64'(o_m_user.is_w_first),
                    64'(e.user.is_w_first));
        check_equal("o_m_user.is_cin_last", 64'(o_m_user.is_cin_last),
                    64'(e.user.is_cin_last));
        check_equal("o_m_user.is_cols_1_k2", 64'(o_m_user.is_cols_1_k2),
                    64'(e.user.is_cols_1_k2));
        check_equal("o_m_user.is_top_block", 64'(o_m_user.is_top_block),
                    64'(e.user.is_top_block));
        check_equal("o_m_user.is_bottom_block", 64'(o_m_user.is_bottom_block),
                    64'(e.user.is_bottom_block));
        check_equal("o_m_last", 64'(o_m_last), 64'(e.last));
        n_out++;
        mj++;
        if (mj == pass_len(mk)) begin
          mj = 0;
          mc++;
          if (mc == k_cols_1[mk] + 1) begin
            mc = 0;
            mb++;
            if (mb == k_blocks_1[mk] + 1) begin
              mb = 0;
              mk++;
            end
          end
        end
      end
    end
  end

  initial begin
    wait (DUT.CHK.n_fail != 0);
    $display("a bound assertion on the output stream failed");
    $display("Test failed");
    $fatal(1);
  end

  // watchdog sized from the beat counts
  initial begin
    wait (limit_cycles != 0);
    repeat (limit_cycles) @(posedge i_clk);
    $display("timeout, only %0d of %0d output beats arrived", n_out, total_out);
    $display("Test failed");
    $fatal(1);
  end

endmodule

//--- tb/weight_rotator_chk.sv
// checks the output stream only; n_fail counts the failed assertions
module weight_rotator_chk #(
  parameter int WORD_WIDTH = 8,
  parameter int MEMBERS    = 4
) (
  input logic                          i_clk,
  input logic                          i_arst_n,
  input logic                          i_m_valid,
  input logic                          i_m_ready,
  input logic [WORD_WIDTH*MEMBERS-1:0] i_m_data,
  input rot_beat_pkg::rot_flags_t      i_m_user,
  input logic                          i_m_last
);
  int   fail_stable = 0;
  int   fail_first  = 0;
  int   n_fail;
  logic fire;
  logic pass_start;     // next beat opens a kernel pass

  assign fire   = i_m_valid && i_m_ready;
  assign n_fail = fail_stable + fail_first;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n)  pass_start <= 1'b1;
    else if (fire)  pass_start <= i_m_user.is_cin_last;
  end

  // a stalled beat must not change
  assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (i_m_valid && !i_m_ready) |=> (i_m_valid && $stable(i_m_data) &&
                                   $stable(i_m_user) && $stable(i_m_last)))
  else begin
    fail_stable = fail_stable + 1;
    $error("output beat changed while stalled");
  end

  assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (fire && i_m_user.is_w_first) |-> pass_start)
  else begin
    fail_first = fail_first + 1;
    $error("is_w_first not at the start of a kernel pass");
  end

endmodule

//--- logic/axis_weight_rotator.sv
// input beats are full width; the header occupies the low bits of the first beat of a kernel
module axis_weight_rotator #(
  parameter int WORD_WIDTH = 8,
  parameter int MEMBERS    = 4
) (
  input  logic                          i_clk,
  input  logic                          i_arst_n,
  input  logic                          i_s_valid,
  output logic                          o_s_ready,
  input  logic [WORD_WIDTH*MEMBERS-1:0] i_s_data,
  input  logic                          i_s_last,
  output logic                          o_m_valid,
  input  logic                          i_m_ready,
  output logic [WORD_WIDTH*MEMBERS-1:0] o_m_data,
  output logic                          o_m_last,
  output rot_beat_pkg::rot_flags_t      o_m_user
);
  import rot_cfg_pkg::*;
  import rot_beat_pkg::*;

  localparam int BEAT_W = WORD_WIDTH * MEMBERS;

  // write side
  logic                 wen;
  logic [BITS_ADDR-1:0] waddr;
  bank_sel_t            wbank;
  logic [BEAT_W-1:0]    wdata;

  // handover between loader and sequencer
  rot_hdr_t             hdr;
  logic [BITS_ADDR-1:0] count;
  logic                 bank_full, read_done;
  bank_sel_t            full_bank, done_bank;

  // read side
  logic                 ren, space, flags_valid, seq_last;
  bank_sel_t            rbank;
  logic [BITS_ADDR-1:0] raddr;
  rot_flags_t           flags;
  logic [BEAT_W-1:0]    rdata0, rdata1, rdata;

  weight_loader #(
    .WORD_WIDTH (WORD_WIDTH),
    .MEMBERS    (MEMBERS)
  ) LOADER (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_s_valid   (i_s_valid),
    .o_s_ready   (o_s_ready),
    .i_s_data    (i_s_data),
    .i_s_last    (i_s_last),
    .o_wen       (wen),
    .o_waddr     (waddr),
    .o_wbank     (wbank),
    .o_wdata     (wdata),
    .o_hdr       (hdr),
    .o_count     (count),
    .o_bank_full (bank_full),
    .o_full_bank (full_bank),
    .i_read_done (read_done),
    .i_done_bank (done_bank)
  );

  weight_bank #(
    .WORD_WIDTH (WORD_WIDTH),
    .MEMBERS    (MEMBERS)
  ) BANK0 (
    .i_clk   (i_clk),
    .i_wen   (wen && (wbank == 1'b0)),
    .i_waddr (waddr),
    .i_wdata (wdata),
    .i_ren   (ren && (rbank == 1'b0)),
    .i_raddr (raddr),
    .o_rdata (rdata0)
  );

  weight_bank #(
    .WORD_WIDTH (WORD_WIDTH),
    .MEMBERS    (MEMBERS)
  ) BANK1 (
    .i_clk   (i_clk),
    .i_wen   (wen && (wbank == 1'b1)),
    .i_waddr (waddr),
    .i_wdata (wdata),
    .i_ren   (ren && (rbank == 1'b1)),
    .i_raddr (raddr),
    .o_rdata (rdata1)
  );

  // rbank holds until the last read of a bank has been taken by the skid
  assign rdata = rbank ? rdata1 : rdata0;

  rotation_sequencer SEQ (
    .i_clk         (i_clk),
    .i_arst_n      (i_arst_n),
    .i_bank_full   (bank_full),
    .i_full_bank   (full_bank),
    .i_hdr         (hdr),
    .i_count       (count),
    .o_ren         (ren),
    .o_rbank       (rbank),
    .o_raddr       (raddr),
    .i_space       (space),
    .o_flags_valid (flags_valid),
    .o_flags       (flags),
    .o_last        (seq_last),
    .o_read_done   (read_done),
    .o_done_bank   (done_bank)
  );

  out_skid #(
    .WORD_WIDTH (WORD_WIDTH),
    .MEMBERS    (MEMBERS)
  ) SKID (
    .i_clk     (i_clk),
    .i_arst_n  (i_arst_n),
    .i_valid   (flags_valid),
    .o_space   (space),
    .i_data    (rdata),
    .i_flags   (flags),
    .i_last    (seq_last),
    .o_m_valid (o_m_valid),
    .i_m_ready (i_m_ready),
    .o_m_data  (o_m_data),
    .o_m_user  (o_m_user),
    .o_m_last  (o_m_last)
  );

endmodule

//--- logic/out_skid.sv
// the producer may push only while o_space is high plus one beat still in flight
module out_skid #(
  parameter int WORD_WIDTH = 8,
  parameter int MEMBERS    = 4
) (
  input  logic                          i_clk,
  input  logic                          i_arst_n,
  input  logic                          i_valid,
  output logic                          o_space,
  input  logic [WORD_WIDTH*MEMBERS-1:0] i_data,
  input  rot_beat_pkg::rot_flags_t      i_flags,
  input  logic                          i_last,
  output logic                          o_m_valid,
  input  logic                          i_m_ready,
  output logic [WORD_WIDTH*MEMBERS-1:0] o_m_data,
  output rot_beat_pkg::rot_flags_t      o_m_user,
  output logic                          o_m_last
);
  import rot_beat_pkg::*;

  typedef struct packed {
    logic [WORD_WIDTH*MEMBERS-1:0] data;
    rot_flags_t                    user;
    logic                          last;
  } entry_t;

  entry_t     ent [2];     // ent[0] is the head
  entry_t     in_ent;
  logic [1:0] fill;
  logic       push, pop, wr_idx;

  assign in_ent = '{data: i_data, user: i_flags, last: i_last};
  assign push   = i_valid;
  assign pop    = o_m_valid && i_m_ready;
  // slot after a possible pop
  assign wr_idx = fill[1] | (fill[0] & ~pop);

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      fill <= 2'd0;
    end else if (push && !pop) begin
      fill <= fill + 2'd1;
    end else if (pop && !push) begin
      fill <= fill - 2'd1;
    end
  end

  // head shifts forward only on pop, so outputs hold under a stall
  always_ff @(posedge i_clk) begin
    if (pop)  ent[0]      <= ent[1];
    if (push) ent[wr_idx] <= in_ent;
  end

  assign o_space   = fill == 2'd0;
  assign o_m_valid = fill != 2'd0;
  assign o_m_data  = ent[0].data;
  assign o_m_user  = ent[0].user;
  assign o_m_last  = ent[0].last;

endmodule

//--- logic/rotation_sequencer.sv
// header fields are trusted as given; i_count must equal kh*cin of the latched header
module rotation_sequencer (
  input  logic                              i_clk,
  input  logic                              i_arst_n,
  input  logic                              i_bank_full,
  input  rot_beat_pkg::bank_sel_t           i_full_bank,
  input  rot_cfg_pkg::rot_hdr_t             i_hdr,
  input  logic [rot_cfg_pkg::BITS_ADDR-1:0] i_count,
  output logic                              o_ren,
  output rot_beat_pkg::bank_sel_t           o_rbank,
  output logic [rot_cfg_pkg::BITS_ADDR-1:0] o_raddr,
  input  logic                              i_space,
  output logic                              o_flags_valid,
  output rot_beat_pkg::rot_flags_t          o_flags,
  output logic                              o_last,
  output logic                              o_read_done,
  output rot_beat_pkg::bank_sel_t           o_done_bank
);
  import rot_cfg_pkg::*;
  import rot_beat_pkg::*;

  localparam int BITS_KH = BITS_KH2 + 1;

  typedef enum logic [1:0] {IDLE, READ, SWITCH} rstate_t;

  rstate_t                state;
  rot_hdr_t               hdr;
  logic [BITS_ADDR-1:0]   count, raddr;
  logic [BITS_KH-1:0]     kh_1, cnt_kh;
  logic [BITS_CIN-1:0]    cnt_cin;
  logic [BITS_COLS-1:0]   cnt_cols;
  logic [BITS_BLOCKS-1:0] cnt_blocks;
  logic                   last_kh, last_cin, last_cols, last_blocks, last_all;
  logic                   start, rd_fire;
  rot_flags_t             flags;

  assign start    = (state == IDLE) && i_bank_full;
  assign rd_fire  = (state == READ) && i_space;     // paced by the output buffer
  assign kh_1     = {hdr.kh2, 1'b0};
  assign last_all = last_kh && last_cin && last_cols && last_blocks;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state   <= IDLE;
      o_rbank <= 1'b0;
    end else begin
      unique case (state)
        IDLE: begin
          if (i_bank_full) begin
            state   <= READ;
            o_rbank <= i_full_bank;
          end
        end
        READ:    if (rd_fire && last_all) state <= SWITCH;
        SWITCH:  state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (start) begin
      hdr   <= i_hdr;
      count <= i_count;
    end
  end

  // nested down-counters kh -> cin -> cols -> blocks
  // each last bit is registered, so it is valid in the same cycle as its count
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      raddr       <= '0;
      cnt_kh      <= '0;
      cnt_cin     <= '0;
      cnt_cols    <= '0;
      cnt_blocks  <= '0;
      last_kh     <= 1'b0;
      last_cin    <= 1'b0;
      last_cols   <= 1'b0;
      last_blocks <= 1'b0;
    end else if (start) begin
      raddr       <= '0;
      cnt_kh      <= {i_hdr.kh2, 1'b0};
      last_kh     <= i_hdr.kh2 == '0;
      cnt_cin     <= i_hdr.cin_1;
      last_cin    <= i_hdr.cin_1 == '0;
      cnt_cols    <= i_hdr.cols_1;
      last_cols   <= i_hdr.cols_1 == '0;
      cnt_blocks  <= i_hdr.blocks_1;
      last_blocks <= i_hdr.blocks_1 == '0;
    end else if (rd_fire) begin
      raddr   <= (raddr == count - 1'b1) ? '0 : raddr + 1'b1;   // wraps per column pass
      cnt_kh  <= last_kh ? kh_1 : cnt_kh - 1'b1;
      last_kh <= last_kh ? (hdr.kh2 == '0) : (cnt_kh == BITS_KH'(1));
      if (last_kh) begin
        cnt_cin  <= last_cin ? hdr.cin_1 : cnt_cin - 1'b1;
        last_cin <= last_cin ? (hdr.cin_1 == '0) : (cnt_cin == BITS_CIN'(1));
        if (last_cin) begin
          cnt_cols  <= last_cols ? hdr.cols_1 : cnt_cols - 1'b1;
          last_cols <= last_cols ? (hdr.cols_1 == '0) : (cnt_cols == BITS_COLS'(1));
          if (last_cols) begin
            cnt_blocks  <= last_blocks ? hdr.blocks_1 : cnt_blocks - 1'b1;
            last_blocks <= last_blocks ? (hdr.blocks_1 == '0)
                                       : (cnt_blocks == BITS_BLOCKS'(1));
          end
        end
      end
    end
  end

  always_comb begin
    flags.kw2             = hdr.kw2;
    flags.is_w_first      = (cnt_cols == hdr.cols_1) && (cnt_cin == hdr.cin_1) &&
                            (cnt_kh == kh_1);
    flags.is_cin_last     = last_kh && last_cin;
    // cnt_cols counts down, so c = cols-1-kw2 means cnt_cols == kw2
    flags.is_cols_1_k2    = cnt_cols == BITS_COLS'(hdr.kw2);
    flags.is_top_block    = cnt_blocks == hdr.blocks_1;
    flags.is_bottom_block = last_blocks;
  end

  // align flags with the bank read latency
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) o_flags_valid <= 1'b0;
    else           o_flags_valid <= rd_fire;
  end

  always_ff @(posedge i_clk) begin
    if (rd_fire) begin
      o_flags <= flags;
      o_last  <= last_all;
    end
  end

  assign o_ren       = rd_fire;
  assign o_raddr     = raddr;
  assign o_read_done = state == SWITCH;   // last read already left the bank
  assign o_done_bank = o_rbank;

endmodule

//--- logic/weight_loader.sv
// header beat must not carry i_s_last; a kernel holds at least one weight beat and fits a bank
module weight_loader #(
  parameter int WORD_WIDTH = 8,
  parameter int MEMBERS    = 4
) (
  input  logic                                i_clk,
  input  logic                                i_arst_n,
  input  logic                                i_s_valid,
  output logic                                o_s_ready,
  input  logic [WORD_WIDTH*MEMBERS-1:0]       i_s_data,
  input  logic                                i_s_last,
  output logic                                o_wen,
  output logic [rot_cfg_pkg::BITS_ADDR-1:0]   o_waddr,
  output rot_beat_pkg::bank_sel_t             o_wbank,
  output logic [WORD_WIDTH*MEMBERS-1:0]       o_wdata,
  output rot_cfg_pkg::rot_hdr_t               o_hdr,
  output logic [rot_cfg_pkg::BITS_ADDR-1:0]   o_count,
  output logic                                o_bank_full,
  output rot_beat_pkg::bank_sel_t             o_full_bank,
  input  logic                                i_read_done,
  input  rot_beat_pkg::bank_sel_t             i_done_bank
);
  import rot_cfg_pkg::*;
  import rot_beat_pkg::*;

  typedef enum logic [1:0] {IDLE, GET_HDR, WRITE, SWITCH} wstate_t;

  wstate_t              state, state_next;
  bank_sel_t            wr_bank;           // bank being filled
  bank_sel_t            rd_bank;           // oldest filled bank, next to be replayed
  logic [1:0]           done_write;
  logic [1:0]           done_read;
  rot_hdr_t             hdr_q   [2];
  logic [BITS_ADDR-1:0] count_q [2];
  logic [BITS_ADDR-1:0] wcount;
  logic                 s_fire, hdr_fire, s_last_fire;

  assign o_s_ready   = (state == GET_HDR) || (state == WRITE);
  assign s_fire      = i_s_valid && o_s_ready;
  assign hdr_fire    = s_fire && (state == GET_HDR);
  assign s_last_fire = s_fire && (state == WRITE) && i_s_last;

  always_comb begin
    state_next = state;
    unique case (state)
      IDLE:    if (done_read[wr_bank]) state_next = GET_HDR;   // wait until bank is free
      GET_HDR: if (s_fire)             state_next = WRITE;
      WRITE:   if (s_last_fire)        state_next = SWITCH;
      SWITCH:                          state_next = IDLE;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state      <= IDLE;
      wr_bank    <= 1'b0;
      rd_bank    <= 1'b0;
      done_write <= 2'b00;
      done_read  <= 2'b11;      // both banks start empty
      wcount     <= '0;
    end else begin
      state <= state_next;

      if (state == GET_HDR) wcount <= '0;
      else if (o_wen)       wcount <= wcount + 1'b1;

      // bank filled, hand it over
      if (s_last_fire) begin
        done_write[wr_bank] <= 1'b1;
        done_read[wr_bank]  <= 1'b0;
        wr_bank             <= ~wr_bank;
      end

      // replay finished, bank can be refilled
      if (i_read_done) begin
        done_read[i_done_bank]  <= 1'b1;
        done_write[i_done_bank] <= 1'b0;
        rd_bank                 <= ~i_done_bank;
      end
    end
  end

  // header and length per bank
  always_ff @(posedge i_clk) begin
    if (hdr_fire)    hdr_q[wr_bank]   <= rot_hdr_t'(i_s_data[HDR_BITS-1:0]);
    if (s_last_fire) count_q[wr_bank] <= wcount + 1'b1;
  end

  assign o_wen   = s_fire && (state == WRITE);
  assign o_waddr = wcount;
  assign o_wbank = wr_bank;
  assign o_wdata = i_s_data;

  assign o_bank_full = done_write[rd_bank];
  assign o_full_bank = rd_bank;
  assign o_hdr       = hdr_q[rd_bank];
  assign o_count     = count_q[rd_bank];

endmodule

//--- logic/weight_bank.sv
// no read-during-write forwarding; the banks are never read and written at once
module weight_bank #(
  parameter int WORD_WIDTH = 8,
  parameter int MEMBERS    = 4
) (
  input  logic                              i_clk,
  input  logic                              i_wen,
  input  logic [rot_cfg_pkg::BITS_ADDR-1:0] i_waddr,
  input  logic [WORD_WIDTH*MEMBERS-1:0]     i_wdata,
  input  logic                              i_ren,
  input  logic [rot_cfg_pkg::BITS_ADDR-1:0] i_raddr,
  output logic [WORD_WIDTH*MEMBERS-1:0]     o_rdata
);
  import rot_cfg_pkg::*;

  localparam int DEPTH = 2 ** BITS_ADDR;

  logic [WORD_WIDTH*MEMBERS-1:0] mem [DEPTH];

  always_ff @(posedge i_clk) begin
    if (i_wen) mem[i_waddr] <= i_wdata;
  end

  // one cycle read latency, output holds between reads
  always_ff @(posedge i_clk) begin
    if (i_ren) o_rdata <= mem[i_raddr];
  end

endmodule

//--- logic/rot_beat_pkg.sv
// flag layout of the output user word; field order is fixed for downstream consumers
package rot_beat_pkg;

  // index of one of the two ping-pong banks
  typedef logic bank_sel_t;

  // position flags that travel with every output weight beat
  typedef struct packed {
    logic [rot_cfg_pkg::BITS_KW2-1:0] kw2;   // copied from the header
    logic is_w_first;        // first beat of column 0
    logic is_cin_last;       // last beat of one kernel pass
    logic is_cols_1_k2;      // column cols-1-kw2
    logic is_top_block;
    logic is_bottom_block;
  } rot_flags_t;

endpackage

//--- logic/rot_cfg_pkg.sv
// limits are fixed at compile time; the header must fit in the low bits of one input beat
package rot_cfg_pkg;

  // largest supported kernel and image, kernel height is odd
  localparam int KH_MAX     = 7;
  localparam int CIN_MAX    = 64;
  localparam int COLS_MAX   = 32;
  localparam int BLOCKS_MAX = 16;

  localparam int BITS_KH2    = $clog2(KH_MAX / 2 + 1);
  localparam int BITS_KW2    = BITS_KH2;             // kernel width shares the height limit
  localparam int BITS_CIN    = $clog2(CIN_MAX);      // holds cin-1
  localparam int BITS_COLS   = $clog2(COLS_MAX);
  localparam int BITS_BLOCKS = $clog2(BLOCKS_MAX);

  // must hold the beat count kh*cin itself, not just the last address
  localparam int BITS_ADDR = $clog2(KH_MAX * CIN_MAX + 1);

  localparam int HDR_BITS = BITS_KH2 + BITS_KW2 + BITS_CIN + BITS_COLS + BITS_BLOCKS;

  // first beat of a kernel, kh2 in the top bits
  typedef struct packed {
    logic [BITS_KH2-1:0]    kh2;       // kh = 2*kh2+1
    logic [BITS_KW2-1:0]    kw2;
    logic [BITS_CIN-1:0]    cin_1;
    logic [BITS_COLS-1:0]   cols_1;
    logic [BITS_BLOCKS-1:0] blocks_1;
  } rot_hdr_t;

endpackage
